/* flist.f */
+incdir+verilog
verilog/wb_pkg.sv
verilog/wb_stall_ctrl.sv
verilog/wb_stage_reg.sv
verilog/wb_regfile.sv
verilog/wb_top.sv
verification/wb_chk.sv
verification/wb_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the write-back testbench with Verilator, runs it and scans the log for the result
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module wb_tb -f flist.f -o wb_sim \
    || { echo "Verilator build failed"; exit 1; }
./obj_dir/wb_sim > sim.log 2>&1 || echo "Simulator exited with a nonzero status"
cat sim.log
grep -q '^>>> FAIL$' sim.log && { echo "Simulation failed"; exit 1; }
grep -q '^>>> PASS$' sim.log || { echo "Simulation ended without a result"; exit 1; }
echo "Simulation passed"
exit 0

/* verification/wb_tb.sv */
// Testbench for the write-back subsystem with reference register model and directed tests
`timescale 1ns/1ps
`include "wb_defs.svh"

module wb_tb;

    import wb_pkg::*;

    // Estimated cycles per test, the run is cut off at twice their sum
    localparam int LEN_RESET_SEQ  = 10;
    localparam int LEN_RESET_TEST = 34;
    localparam int LEN_SINGLE     = 12;
    localparam int LEN_MULTI      = 12;
    localparam int LEN_X0         = 14;
    localparam int LEN_HOLD       = 22;
    localparam int LEN_SQUASH     = 12;
    localparam int TOTAL_CYCLES   = LEN_RESET_SEQ + LEN_RESET_TEST + LEN_SINGLE + LEN_MULTI
                                    + LEN_X0 + LEN_HOLD + LEN_SQUASH;
    localparam int TIMEOUT_CYCLES = 2 * TOTAL_CYCLES;

    logic                  clk;
    logic                  rst_n;
    logic                  hold_req;
    logic                  flush_req;
    logic                  in_ready;
    logic [`WB_REG_AW-1:0] rs1_addr;
    logic [`WB_XLEN-1:0]   rs1_data;
    logic [`WB_REG_AW-1:0] rs2_addr;
    logic [`WB_XLEN-1:0]   rs2_data;

    logic                  slot_valid [3];
    logic [`WB_REG_AW-1:0] slot_addr  [3];
    logic [`WB_XLEN-1:0]   slot_data  [3];

    logic [`WB_XLEN-1:0]   model_regs [`WB_NUM_REGS];
    wb_ctrl_e              exp_state;
    int                    cycle_count  = 0;
    int                    test_errors  = 0;
    int                    total_errors = 0;
    int                    tests_run    = 0;
    int                    tests_passed = 0;

    wb_top dut0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .hold_req   (hold_req),
        .flush_req  (flush_req),
        .alu0_valid (slot_valid[LANE_ALU0]),
        .alu0_addr  (slot_addr[LANE_ALU0]),
        .alu0_data  (slot_data[LANE_ALU0]),
        .alu1_valid (slot_valid[LANE_ALU1]),
        .alu1_addr  (slot_addr[LANE_ALU1]),
        .alu1_data  (slot_data[LANE_ALU1]),
        .mem_valid  (slot_valid[LANE_MEM]),
        .mem_addr   (slot_addr[LANE_MEM]),
        .mem_data   (slot_data[LANE_MEM]),
        .in_ready   (in_ready),
        .rs1_addr   (rs1_addr),
        .rs1_data   (rs1_data),
        .rs2_addr   (rs2_addr),
        .rs2_data   (rs2_data)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display(">>> FAIL");
            $finish;
        end
    end

    // ####################
    // Reference model
    // ####################
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            exp_state <= WB_RUN;
        end else if (flush_req) begin
            exp_state <= WB_SQUASH;   // Flush has priority over hold
        end else if (hold_req) begin
            exp_state <= WB_HOLD;
        end else begin
            exp_state <= WB_RUN;
        end
    end

    // Lanes in enum order, a later lane overwrites an earlier one
    task model_commit;
        for (int l = int'(LANE_ALU0); l <= int'(LANE_MEM); l++) begin
            if (slot_valid[l] && (slot_addr[l] != '0)) begin
                model_regs[slot_addr[l]] = slot_data[l];
            end
        end
    endtask

    // ####################
    // Driving and checking
    // ####################
    task set_lane(input wb_lane_e lane, input logic [`WB_REG_AW-1:0] a,
                  input logic [`WB_XLEN-1:0] d);
        slot_valid[lane] = 1'b1;
        slot_addr[lane]  = a;
        slot_data[lane]  = d;
    endtask

    task check_ready(input logic expected, input string ctx);
        assert (in_ready == expected) else begin
            $display("FAILED in_ready (%s): expected %h, got %h", ctx, expected, in_ready);
            test_errors++;
        end
    endtask

    // Waits for acceptance, then for the edge that writes the register file
    task send_slot;
        logic     rdy;
        wb_ctrl_e st;
        rdy = 1'b0;
        st  = WB_RUN;
        while (!rdy) begin
            @(negedge clk);
            rdy = in_ready;
            st  = exp_state;
            check_ready(exp_state != WB_HOLD, "handshake");
            @(posedge clk);
            #1;
        end
        if (st == WB_RUN) begin
            model_commit();
        end
        for (int l = 0; l < 3; l++) begin
            slot_valid[l] = 1'b0;
        end
        @(posedge clk);
        #1;
    endtask

    task check_regs(input logic [`WB_REG_AW-1:0] a1, input logic [`WB_REG_AW-1:0] a2,
                    input string ctx);
        rs1_addr = a1;
        rs2_addr = a2;
        @(negedge clk);
        assert (rs1_data == model_regs[a1]) else begin
            $display("FAILED rs1_data (%s) x%0d: expected %h, got %h",
                     ctx, a1, model_regs[a1], rs1_data);
            test_errors++;
        end
        assert (rs2_data == model_regs[a2]) else begin
            $display("FAILED rs2_data (%s) x%0d: expected %h, got %h",
                     ctx, a2, model_regs[a2], rs2_data);
            test_errors++;
        end
        @(posedge clk);
        #1;
    endtask

    task write_single(input wb_lane_e lane, input logic [`WB_REG_AW-1:0] a);
        set_lane(lane, a, $urandom());
        send_slot();
        check_regs(a, a, lane.name());
    endtask

    task finish_test(input string name);
        tests_run++;
        if (test_errors == 0) begin
            tests_passed++;
            $display("Test %s: passed", name);
        end else begin
            $display("Test %s: failed with %0d errors", name, test_errors);
        end
        total_errors += test_errors;
        test_errors = 0;
    endtask

    // ####################
    // Directed tests
    // ####################
    task test_reset_state;
        check_ready(1'b1, "after reset");
        for (int i = 0; i < `WB_NUM_REGS; i++) begin
            check_regs(5'(i), 5'(`WB_NUM_REGS - 1 - i), "reset");
        end
        finish_test("reset_state");
    endtask

    task test_single_lanes;
        write_single(LANE_ALU0, 5'd5);
        write_single(LANE_ALU1, 5'd6);
        write_single(LANE_MEM, 5'd7);
        finish_test("single_lanes");
    endtask

    task test_multi_lane;
        set_lane(LANE_ALU0, 5'd10, $urandom());
        set_lane(LANE_ALU1, 5'd11, $urandom());
        set_lane(LANE_MEM, 5'd12, $urandom());
        send_slot();
        check_regs(5'd10, 5'd11, "distinct");
        check_regs(5'd12, 5'd10, "distinct");
        set_lane(LANE_ALU0, 5'd13, $urandom());
        set_lane(LANE_ALU1, 5'd13, $urandom());
        set_lane(LANE_MEM, 5'd13, $urandom());
        send_slot();
        check_regs(5'd13, 5'd13, "all lanes to one register");
        set_lane(LANE_ALU0, 5'd14, $urandom());
        set_lane(LANE_ALU1, 5'd14, $urandom());
        send_slot();
        check_regs(5'd14, 5'd13, "two ALU lanes to one register");
        finish_test("multi_lane");
    endtask

    task test_x0_writes;
        write_single(LANE_ALU0, 5'd0);
        write_single(LANE_ALU1, 5'd0);
        write_single(LANE_MEM, 5'd0);
        set_lane(LANE_ALU0, 5'd0, $urandom());
        set_lane(LANE_ALU1, 5'd0, $urandom());
        set_lane(LANE_MEM, 5'd0, $urandom());
        send_slot();
        check_regs(5'd0, 5'd7, "x0 from all lanes");
        finish_test("x0_writes");
    endtask

    task test_hold;
        write_single(LANE_ALU0, 5'd20);
        hold_req = 1'b1;
        @(posedge clk);
        #1;
        check_ready(1'b0, "hold");
        set_lane(LANE_MEM, 5'd20, $urandom());   // Offered while the stage is held
        repeat (4) begin
            check_ready(1'b0, "hold");
            check_regs(5'd20, 5'd20, "held slot");
        end
        hold_req = 1'b0;
        send_slot();
        check_regs(5'd20, 5'd20, "after hold");
        write_single(LANE_ALU1, 5'd20);
        repeat (3) begin
            check_regs(5'd20, 5'd20, "no duplicate after hold");
        end
        finish_test("hold");
    endtask

    task test_squash;
        write_single(LANE_ALU0, 5'd24);
        flush_req = 1'b1;
        @(posedge clk);
        #1;
        flush_req = 1'b0;
        check_ready(1'b1, "squash");
        set_lane(LANE_ALU0, 5'd24, $urandom());
        set_lane(LANE_MEM, 5'd25, $urandom());
        send_slot();
        check_regs(5'd24, 5'd25, "squashed slot");
        write_single(LANE_ALU1, 5'd24);
        finish_test("squash");
    endtask

    // ####################
    // Main sequence
    // ####################
    initial begin
        void'($urandom(32'hffa8));
        rst_n     = 1'b0;
        hold_req  = 1'b0;
        flush_req = 1'b0;
        rs1_addr  = '0;
        rs2_addr  = '0;
        for (int l = 0; l < 3; l++) begin
            slot_valid[l] = 1'b0;
            slot_addr[l]  = '0;
            slot_data[l]  = '0;
        end
        for (int i = 0; i < `WB_NUM_REGS; i++) begin
            model_regs[i] = '0;
        end
        repeat (LEN_RESET_SEQ) @(posedge clk);
        #1;
        rst_n = 1'b1;
        test_reset_state();
        test_single_lanes();
        test_multi_lane();
        test_x0_writes();
        test_hold();
        test_squash();
        $display("Summary: %0d tests run, %0d passed, %0d failed, %0d errors",
                 tests_run, tests_passed, tests_run - tests_passed, total_errors);
        if (total_errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

/* verification/wb_chk.sv */
// Concurrent assertions on stage control state, ready and x0 reads, bound into wb_top
`timescale 1ns/1ps
`include "wb_defs.svh"

module wb_chk (
    input  logic                  clk,
    input  logic                  rst_n,
    input  wb_pkg::wb_ctrl_e      wb_state,
    input  logic                  in_ready,
    input  logic [`WB_REG_AW-1:0] rs1_addr,
    input  logic [`WB_XLEN-1:0]   rs1_data
);

    import wb_pkg::*;

    // ####################
    // Control
    // ####################
    ready_vs_state: assert property (@(posedge clk) disable iff (!rst_n)
        (in_ready == 1'b0) == (wb_state == WB_HOLD))
        else $error("in_ready does not match the hold state");

    run_after_reset: assert property (@(posedge clk)
        $rose(rst_n) |-> (wb_state == WB_RUN))
        else $error("Stage control is not in run right after reset");   // Reset value seen

    // ####################
    // Register file
    // ####################
    x0_reads_zero: assert property (@(posedge clk) disable iff (!rst_n)
        (rs1_addr == '0) |-> (rs1_data == '0))
        else $error("x0 read returned a nonzero value");

endmodule

bind wb_top wb_chk chk0 (
    .clk      (clk),
    .rst_n    (rst_n),
    .wb_state (wb_state),
    .in_ready (in_ready),
    .rs1_addr (rs1_addr),
    .rs1_data (rs1_data)
);

/* verilog/wb_top.sv */
// Write-back subsystem top joining the stall controller, stage register and register file
`timescale 1ns/1ps
`include "wb_defs.svh"

module wb_top (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  hold_req,
    input  logic                  flush_req,
    input  logic                  alu0_valid,
    input  logic [`WB_REG_AW-1:0] alu0_addr,
    input  logic [`WB_XLEN-1:0]   alu0_data,
    input  logic                  alu1_valid,
    input  logic [`WB_REG_AW-1:0] alu1_addr,
    input  logic [`WB_XLEN-1:0]   alu1_data,
    input  logic                  mem_valid,
    input  logic [`WB_REG_AW-1:0] mem_addr,
    input  logic [`WB_XLEN-1:0]   mem_data,
    output logic                  in_ready,
    input  logic [`WB_REG_AW-1:0] rs1_addr,
    output logic [`WB_XLEN-1:0]   rs1_data,
    input  logic [`WB_REG_AW-1:0] rs2_addr,
    output logic [`WB_XLEN-1:0]   rs2_data
);

    import wb_pkg::*;

    wb_ctrl_e              wb_state;
    logic                  wb_alu0_en;
    logic [`WB_REG_AW-1:0] wb_alu0_addr;
    logic [`WB_XLEN-1:0]   wb_alu0_data;
    logic                  wb_alu1_en;
    logic [`WB_REG_AW-1:0] wb_alu1_addr;
    logic [`WB_XLEN-1:0]   wb_alu1_data;
    logic                  wb_mem_en;
    logic [`WB_REG_AW-1:0] wb_mem_addr;
    logic [`WB_XLEN-1:0]   wb_mem_data;

    // ####################
    // Control
    // ####################
    wb_stall_ctrl u_stall (
        .clk       (clk),
        .rst_n     (rst_n),
        .hold_req  (hold_req),
        .flush_req (flush_req),
        .wb_state  (wb_state),
        .in_ready  (in_ready)
    );

    // ####################
    // Datapath
    // ####################
    wb_stage_reg u_stage (
        .clk          (clk),
        .rst_n        (rst_n),
        .wb_state     (wb_state),
        .alu0_valid   (alu0_valid),
        .alu0_addr    (alu0_addr),
        .alu0_data    (alu0_data),
        .alu1_valid   (alu1_valid),
        .alu1_addr    (alu1_addr),
        .alu1_data    (alu1_data),
        .mem_valid    (mem_valid),
        .mem_addr     (mem_addr),
        .mem_data     (mem_data),
        .wb_alu0_en   (wb_alu0_en),
        .wb_alu0_addr (wb_alu0_addr),
        .wb_alu0_data (wb_alu0_data),
        .wb_alu1_en   (wb_alu1_en),
        .wb_alu1_addr (wb_alu1_addr),
        .wb_alu1_data (wb_alu1_data),
        .wb_mem_en    (wb_mem_en),
        .wb_mem_addr  (wb_mem_addr),
        .wb_mem_data  (wb_mem_data)
    );

    wb_regfile u_rf (
        .clk          (clk),
        .rst_n        (rst_n),
        .wb_alu0_en   (wb_alu0_en),
        .wb_alu0_addr (wb_alu0_addr),
        .wb_alu0_data (wb_alu0_data),
        .wb_alu1_en   (wb_alu1_en),
        .wb_alu1_addr (wb_alu1_addr),
        .wb_alu1_data (wb_alu1_data),
        .wb_mem_en    (wb_mem_en),
        .wb_mem_addr  (wb_mem_addr),
        .wb_mem_data  (wb_mem_data),
        .rs1_addr     (rs1_addr),
        .rs1_data     (rs1_data),
        .rs2_addr     (rs2_addr),
        .rs2_data     (rs2_data)
    );

endmodule

/* verilog/wb_regfile.sv */
// Register file with three prioritized write ports, two read ports and x0 tied to zero
`timescale 1ns/1ps
`include "wb_defs.svh"

module wb_regfile (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  wb_alu0_en,
    input  logic [`WB_REG_AW-1:0] wb_alu0_addr,
    input  logic [`WB_XLEN-1:0]   wb_alu0_data,
    input  logic                  wb_alu1_en,
    input  logic [`WB_REG_AW-1:0] wb_alu1_addr,
    input  logic [`WB_XLEN-1:0]   wb_alu1_data,
    input  logic                  wb_mem_en,
    input  logic [`WB_REG_AW-1:0] wb_mem_addr,
    input  logic [`WB_XLEN-1:0]   wb_mem_data,
    input  logic [`WB_REG_AW-1:0] rs1_addr,
    output logic [`WB_XLEN-1:0]   rs1_data,
    input  logic [`WB_REG_AW-1:0] rs2_addr,
    output logic [`WB_XLEN-1:0]   rs2_data
);

    import wb_pkg::*;

    localparam int NUM_LANES = int'(LANE_MEM) + 1;

    logic [`WB_XLEN-1:0]   regs    [`WB_NUM_REGS];
    logic                  wr_en   [NUM_LANES];
    logic [`WB_REG_AW-1:0] wr_addr [NUM_LANES];
    logic [`WB_XLEN-1:0]   wr_data [NUM_LANES];

    // ####################
    // Write ports
    // ####################
    assign wr_en[LANE_ALU0]   = wb_alu0_en;
    assign wr_addr[LANE_ALU0] = wb_alu0_addr;
    assign wr_data[LANE_ALU0] = wb_alu0_data;
    assign wr_en[LANE_ALU1]   = wb_alu1_en;
    assign wr_addr[LANE_ALU1] = wb_alu1_addr;
    assign wr_data[LANE_ALU1] = wb_alu1_data;
    assign wr_en[LANE_MEM]    = wb_mem_en;
    assign wr_addr[LANE_MEM]  = wb_mem_addr;
    assign wr_data[LANE_MEM]  = wb_mem_data;

    // Lanes are visited in enum order, so the last matching write (memory) takes effect
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `WB_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            for (int l = int'(LANE_ALU0); l <= int'(LANE_MEM); l++) begin
                if (wr_en[l] && (wr_addr[l] != '0)) begin   // x0 is never written
                    regs[wr_addr[l]] <= wr_data[l];
                end
            end
        end
    end

    // ####################
    // Read ports
    // ####################
    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

/* verilog/wb_stage_reg.sv */
// Three-lane write-back pipeline register with run, hold and squash behavior
`timescale 1ns/1ps
`include "wb_defs.svh"

module wb_stage_reg (
    input  logic                  clk,
    input  logic                  rst_n,
    input  wb_pkg::wb_ctrl_e      wb_state,
    input  logic                  alu0_valid,
    input  logic [`WB_REG_AW-1:0] alu0_addr,
    input  logic [`WB_XLEN-1:0]   alu0_data,
    input  logic                  alu1_valid,
    input  logic [`WB_REG_AW-1:0] alu1_addr,
    input  logic [`WB_XLEN-1:0]   alu1_data,
    input  logic                  mem_valid,
    input  logic [`WB_REG_AW-1:0] mem_addr,
    input  logic [`WB_XLEN-1:0]   mem_data,
    output logic                  wb_alu0_en,
    output logic [`WB_REG_AW-1:0] wb_alu0_addr,
    output logic [`WB_XLEN-1:0]   wb_alu0_data,
    output logic                  wb_alu1_en,
    output logic [`WB_REG_AW-1:0] wb_alu1_addr,
    output logic [`WB_XLEN-1:0]   wb_alu1_data,
    output logic                  wb_mem_en,
    output logic [`WB_REG_AW-1:0] wb_mem_addr,
    output logic [`WB_XLEN-1:0]   wb_mem_data
);

    import wb_pkg::*;

    localparam int NUM_LANES = int'(LANE_MEM) + 1;

    logic                  in_valid [NUM_LANES];
    logic [`WB_REG_AW-1:0] in_addr  [NUM_LANES];
    logic [`WB_XLEN-1:0]   in_data  [NUM_LANES];
    logic                  st_en    [NUM_LANES];
    logic [`WB_REG_AW-1:0] st_addr  [NUM_LANES];
    logic [`WB_XLEN-1:0]   st_data  [NUM_LANES];

    // ####################
    // Lane gathering
    // ####################
    assign in_valid[LANE_ALU0] = alu0_valid;
    assign in_addr[LANE_ALU0]  = alu0_addr;
    assign in_data[LANE_ALU0]  = alu0_data;
    assign in_valid[LANE_ALU1] = alu1_valid;
    assign in_addr[LANE_ALU1]  = alu1_addr;
    assign in_data[LANE_ALU1]  = alu1_data;
    assign in_valid[LANE_MEM]  = mem_valid;
    assign in_addr[LANE_MEM]   = mem_addr;
    assign in_data[LANE_MEM]   = mem_data;

    // ####################
    // Stage registers
    // ####################
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int l = 0; l < NUM_LANES; l++) begin
                st_en[l] <= 1'b0;
            end
        end else begin
            for (int l = 0; l < NUM_LANES; l++) begin
                case (wb_state)
                    WB_RUN:    st_en[l] <= in_valid[l];
                    WB_SQUASH: st_en[l] <= 1'b0;   // Younger slot is dropped
                    default:   st_en[l] <= st_en[l];
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int l = 0; l < NUM_LANES; l++) begin
            if (wb_state == WB_RUN) begin
                st_addr[l] <= in_addr[l];
                st_data[l] <= in_data[l];
            end else if (wb_state == WB_SQUASH) begin
                st_addr[l] <= '0;
                st_data[l] <= '0;
            end
        end
    end

    assign wb_alu0_en   = st_en[LANE_ALU0];
    assign wb_alu0_addr = st_addr[LANE_ALU0];
    assign wb_alu0_data = st_data[LANE_ALU0];
    assign wb_alu1_en   = st_en[LANE_ALU1];
    assign wb_alu1_addr = st_addr[LANE_ALU1];
    assign wb_alu1_data = st_data[LANE_ALU1];
    assign wb_mem_en    = st_en[LANE_MEM];
    assign wb_mem_addr  = st_addr[LANE_MEM];
    assign wb_mem_data  = st_data[LANE_MEM];

endmodule

/* verilog/wb_stall_ctrl.sv */
// Stall controller turning hold and flush requests into the stage control state and ready
`timescale 1ns/1ps

module wb_stall_ctrl (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             hold_req,
    input  logic             flush_req,
    output wb_pkg::wb_ctrl_e wb_state,
    output logic             in_ready
);

    import wb_pkg::*;

    wb_ctrl_e next_state;

    // ####################
    // Request priority
    // ####################
    always_comb begin
        if (flush_req) begin
            next_state = WB_SQUASH;   // Flush wins over hold
        end else if (hold_req) begin
            next_state = WB_HOLD;
        end else begin
            next_state = WB_RUN;
        end
    end

    // ####################
    // State register
    // ####################
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_state <= WB_RUN;
        end else begin
            wb_state <= next_state;
        end
    end

    // A squashed slot is still taken from upstream, only hold stops the lanes
    assign in_ready = (wb_state != WB_HOLD);

endmodule

/* verilog/wb_pkg.sv */
// Write-back control state enum and result lane enum
package wb_pkg;

    // ####################
    // Stage control
    // ####################
    typedef enum logic [1:0] {
        WB_RUN    = 2'd0,   // Stage loads the incoming slot
        WB_HOLD   = 2'd1,   // Stage keeps its contents, nothing accepted
        WB_SQUASH = 2'd2    // Slot accepted but loaded as zeros
    } wb_ctrl_e;

    // Lane order doubles as the write priority, the highest value wins
    typedef enum logic [1:0] {
        LANE_ALU0 = 2'd0,
        LANE_ALU1 = 2'd1,
        LANE_MEM  = 2'd2
    } wb_lane_e;

endpackage

/* verilog/wb_defs.svh */
// Data width, register address width and register count for the write-back subsystem
`ifndef WB_DEFS_SVH
`define WB_DEFS_SVH

// ####################
// Architectural sizes
// ####################

// Width of a register and of a lane result
`define WB_XLEN 32

// Width of a register address
`define WB_REG_AW 5

// Number of architectural integer registers
`define WB_NUM_REGS 32

`endif
